//--- verilog/aud_pkg.sv
package aud_pkg;

    // bus widths
    localparam int ADDR_W   = 20;   // sample SRAM address
    localparam int SAMPLE_W = 16;   // signed audio sample
    localparam int SPEED_W  = 3;    // speed field from the controller
    localparam int SLOW_W   = 4;    // slow-mode repeat counter

    // playback sequencer states
    localparam int ST_W = 2;

    localparam logic [ST_W-1:0] ST_IDLE  = 2'd0;  // waiting for start strobe
    localparam logic [ST_W-1:0] ST_PAUSE = 2'd1;  // holding position
    localparam logic [ST_W-1:0] ST_FETCH = 2'd2;  // daclrck high, build next sample
    localparam logic [ST_W-1:0] ST_SEND  = 2'd3;  // daclrck low, sample goes out

    // fetch phases inside ST_FETCH, one per cycle
    localparam int PH_W = 2;

    // address registers at the end of this phase
    localparam logic [PH_W-1:0] PH_ADDR    = 2'd0;
    // sram sees the new address
    localparam logic [PH_W-1:0] PH_DRIVE   = 2'd1;
    // sram data captured, samples shift
    localparam logic [PH_W-1:0] PH_CAPTURE = 2'd2;
    // output sample computed, phase holds here
    localparam logic [PH_W-1:0] PH_OUTPUT  = 2'd3;

    // speed encoding as seen by the blocks:
    //   fast mode  -> address step of speed + 1
    //   slow mode  -> each sample lasts speed + 1 frames
    // slow_cnt never exceeds speed, so SLOW_W leaves one spare bit

endpackage

//--- verilog/aud_ctrl_if.sv
`timescale 1ns/1ps

interface aud_ctrl_if import aud_pkg::*; ();

    logic [ST_W-1:0]    state;      // sequencer state
    logic [SPEED_W-1:0] speed;      // latched config
    logic               is_slow;
    logic               slow_mode;  // 0 repeat, 1 linear
    logic [PH_W-1:0]    phase;      // fetch phase
    logic [SLOW_W-1:0]  slow_cnt;   // frames spent on current sample

    // sequencer side
    modport fsm (
        output state, speed, is_slow, slow_mode,
        input  phase
    );

    // phase and repeat counters
    modport counter (
        input  state, speed, is_slow,
        output phase, slow_cnt
    );

    // address and sample path only look
    modport data (
        input state, speed, is_slow, slow_mode, phase, slow_cnt
    );

endinterface

//--- verilog/aud_play_fsm.sv
`timescale 1ns/1ps

module aud_play_fsm import aud_pkg::*; (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_start,      // controller strobe
    input  logic               i_pause,      // one-cycle toggle pulse
    input  logic               i_daclrck,
    input  logic [SPEED_W-1:0] i_speed,
    input  logic               i_is_slow,
    input  logic               i_slow_mode,
    aud_ctrl_if.fsm            ctrl,
    output logic               o_lrck_rise_send
);

    logic [ST_W-1:0]    state_r;
    logic [ST_W-1:0]    state_nxt;
    logic               pause_r;       // set means paused
    logic [SPEED_W-1:0] speed_r;
    logic               is_slow_r;
    logic               slow_mode_r;

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            ST_IDLE: begin
                if (i_start)
                    state_nxt = ST_PAUSE;
            end
            ST_PAUSE: begin
                if (!pause_r)
                    state_nxt = ST_FETCH;
            end
            ST_FETCH: begin
                if (pause_r)
                    state_nxt = ST_PAUSE;
                else if (!i_daclrck && ctrl.phase == PH_OUTPUT)
                    state_nxt = ST_SEND;   // sample ready, dac takes it
            end
            default: begin                 // ST_SEND
                if (pause_r)
                    state_nxt = ST_PAUSE;
                else if (i_daclrck)
                    state_nxt = ST_FETCH;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r     <= ST_IDLE;
            pause_r     <= 1'b1;
            speed_r     <= '0;
            is_slow_r   <= 1'b0;
            slow_mode_r <= 1'b0;
        end else begin
            state_r <= state_nxt;

            // pause toggles, direction depends on where we are
            if (state_r == ST_IDLE)
                pause_r <= 1'b1;
            else if (i_pause)
                pause_r <= (state_r != ST_PAUSE);

            // config only moves while paused or sending
            if (state_r == ST_IDLE) begin
                speed_r     <= '0;
                is_slow_r   <= 1'b0;
                slow_mode_r <= 1'b0;
            end else if (state_r == ST_PAUSE || state_r == ST_SEND) begin
                speed_r     <= i_speed;
                is_slow_r   <= i_is_slow;
                slow_mode_r <= i_slow_mode;
            end
        end
    end

    assign ctrl.state     = state_r;
    assign ctrl.speed     = speed_r;
    assign ctrl.is_slow   = is_slow_r;
    assign ctrl.slow_mode = slow_mode_r;

    // new dac frame about to start
    assign o_lrck_rise_send = (state_r == ST_SEND) && i_daclrck;

endmodule

//--- verilog/aud_step_counter.sv
`timescale 1ns/1ps

module aud_step_counter import aud_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_lrck_rise_send,  // one pulse per frame
    aud_ctrl_if.counter ctrl
);

    logic [PH_W-1:0]   phase_r;
    logic [SLOW_W-1:0] slow_cnt_r;

    // fetch phase, saturates at PH_OUTPUT
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase_r <= PH_ADDR;
        end else if (ctrl.state != ST_FETCH) begin
            phase_r <= PH_ADDR;
        end else if (phase_r != PH_OUTPUT) begin
            phase_r <= phase_r + 1'b1;
        end
    end

    // how many frames the current slow sample has been played
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            slow_cnt_r <= '0;
        end else if (ctrl.state == ST_IDLE || ctrl.state == ST_PAUSE) begin
            slow_cnt_r <= '0;
        end else if (i_lrck_rise_send && ctrl.is_slow) begin
            if (slow_cnt_r == SLOW_W'(ctrl.speed))
                slow_cnt_r <= '0;                  // last repeat done
            else
                slow_cnt_r <= slow_cnt_r + 1'b1;
        end
    end

    assign ctrl.phase    = phase_r;
    assign ctrl.slow_cnt = slow_cnt_r;

endmodule

//--- verilog/aud_addr_gen.sv
`timescale 1ns/1ps

module aud_addr_gen import aud_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic [ADDR_W-1:0] i_stop_addr,   // last valid sample
    output logic [ADDR_W-1:0] o_sram_addr,
    aud_ctrl_if.data          ctrl
);

    logic [ADDR_W-1:0] addr_r;
    logic [ADDR_W:0]   addr_sum;   // extra bit catches the carry

    always_comb begin
        addr_sum = {1'b0, addr_r};
        if (ctrl.state == ST_IDLE) begin
            addr_sum = '0;
        end else if (ctrl.state == ST_FETCH && ctrl.phase == PH_ADDR) begin
            if (!ctrl.is_slow)
                addr_sum = {1'b0, addr_r} + (ADDR_W + 1)'(ctrl.speed) + 1'b1;
            else if (ctrl.slow_cnt == '0)
                addr_sum = {1'b0, addr_r} + 1'b1;  // move on once per repeat group
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            addr_r <= '0;
        end else if (addr_sum > {1'b0, i_stop_addr}) begin
            addr_r <= '0;                         // wrap to start
        end else begin
            addr_r <= addr_sum[ADDR_W-1:0];
        end
    end

    assign o_sram_addr = addr_r;

endmodule

//--- verilog/aud_interp.sv
`timescale 1ns/1ps

module aud_interp import aud_pkg::*; (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic signed [SAMPLE_W-1:0] i_sram_data,
    output logic signed [SAMPLE_W-1:0] o_dac_data,
    aud_ctrl_if.data                   ctrl
);

    logic signed [SAMPLE_W-1:0]        curr_r;
    logic signed [SAMPLE_W-1:0]        next_r;
    logic signed [SAMPLE_W-1:0]        out_r;
    logic        [SPEED_W:0]           div_cnt;  // speed + 1, up to 8
    logic signed [SAMPLE_W:0]          diff;     // next - curr never overflows
    logic signed [SAMPLE_W+SLOW_W+1:0] prod;
    logic signed [SAMPLE_W+SLOW_W+1:0] quot;
    logic signed [SAMPLE_W+SLOW_W+1:0] mix;
    logic                              shift_en;

    assign div_cnt = {1'b0, ctrl.speed} + 1'b1;

    // linear step, signed divide truncates toward zero
    assign diff = next_r - curr_r;
    assign prod = diff * $signed({1'b0, ctrl.slow_cnt});
    assign quot = prod / $signed({1'b0, div_cnt});
    assign mix  = curr_r + quot;

    // slow mode only fetches at the start of a repeat group
    assign shift_en = !ctrl.is_slow || (ctrl.slow_cnt == '0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            curr_r <= '0;
            next_r <= '0;
            out_r  <= '0;
        end else begin
            case (ctrl.state)
                ST_IDLE: begin
                    next_r <= '0;
                    out_r  <= '0;
                end
                ST_PAUSE: next_r <= i_sram_data;  // preload first sample
                ST_FETCH: begin
                    if (ctrl.phase == PH_CAPTURE && shift_en) begin
                        curr_r <= next_r;
                        next_r <= i_sram_data;
                    end
                    if (ctrl.phase == PH_OUTPUT) begin
                        if (ctrl.is_slow && ctrl.slow_mode)
                            out_r <= mix[SAMPLE_W-1:0];
                        else
                            out_r <= curr_r;      // fast or repeat
                    end
                end
                default: ;                        // hold while sending
            endcase
        end
    end

    assign o_dac_data = out_r;

endmodule

//--- verilog/aud_dsp.sv
`timescale 1ns/1ps

module aud_dsp import aud_pkg::*; (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_start,
    input  logic                       i_pause,
    input  logic [SPEED_W-1:0]         i_speed,
    input  logic                       i_is_slow,
    input  logic                       i_slow_mode,
    input  logic                       i_daclrck,         // sample prepared while high
    input  logic signed [SAMPLE_W-1:0] i_sram_data,
    input  logic [ADDR_W-1:0]          i_sram_stop_addr,
    output logic signed [SAMPLE_W-1:0] o_dac_data,
    output logic                       o_en,
    output logic [ADDR_W-1:0]          o_sram_addr
);

    logic lrck_rise_send;

    aud_ctrl_if ctrl ();

    aud_play_fsm u_fsm (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_start          (i_start),
        .i_pause          (i_pause),
        .i_daclrck        (i_daclrck),
        .i_speed          (i_speed),
        .i_is_slow        (i_is_slow),
        .i_slow_mode      (i_slow_mode),
        .ctrl             (ctrl.fsm),
        .o_lrck_rise_send (lrck_rise_send)
    );

    aud_step_counter u_counter (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_lrck_rise_send (lrck_rise_send),
        .ctrl             (ctrl.counter)
    );

    aud_addr_gen u_addr (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_stop_addr (i_sram_stop_addr),
        .o_sram_addr (o_sram_addr),
        .ctrl        (ctrl.data)
    );

    aud_interp u_interp (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_sram_data (i_sram_data),
        .o_dac_data  (o_dac_data),
        .ctrl        (ctrl.data)
    );

    assign o_en = ~i_daclrck;  // player enable, ungated by state

endmodule

//--- bench/aud_dsp_properties.sv
`timescale 1ns/1ps

module aud_dsp_properties import aud_pkg::*; (
    input logic                       i_clk,
    input logic                       i_rst_n,
    input logic [ADDR_W-1:0]          i_sram_addr,
    input logic [ADDR_W-1:0]          i_stop_addr,
    input logic signed [SAMPLE_W-1:0] i_dac_data,
    input logic [ST_W-1:0]            i_state
);

    // read pointer only steps inside a fetch
    addr_held_outside_fetch: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_state != ST_FETCH) |=> $stable(i_sram_addr)
    ) else $error("o_sram_addr moved outside ST_FETCH");

    // wrap must keep the read pointer inside the sample area
    addr_in_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_sram_addr <= i_stop_addr
    ) else $error("o_sram_addr is above the stop address");

    dac_frozen_in_pause: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_state == ST_PAUSE) |=> $stable(i_dac_data)
    ) else $error("o_dac_data changed while paused");

endmodule

bind aud_dsp aud_dsp_properties u_props (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_sram_addr (o_sram_addr),
    .i_stop_addr (i_sram_stop_addr),
    .i_dac_data  (o_dac_data),
    .i_state     (ctrl.state)
);

//--- bench/aud_dsp_tb.sv
`timescale 1ns/1ps

module aud_dsp_tb import aud_pkg::*; ();

    localparam int MEM_DEPTH    = 64;   // address bits [5:0] index the model
    localparam int HALF_CYCLES  = 16;   // daclrck half period in clocks
    localparam int TOTAL_FRAMES = 4 + 24 + 20 + 24 + 19;
    localparam int CYCLE_LIMIT  = TOTAL_FRAMES * 2 * HALF_CYCLES + 100;

    logic                       i_clk;
    logic                       i_rst_n;
    logic                       i_start;
    logic                       i_pause;
    logic [SPEED_W-1:0]         i_speed;
    logic                       i_is_slow;
    logic                       i_slow_mode;
    logic                       i_daclrck;
    logic signed [SAMPLE_W-1:0] i_sram_data;
    logic [ADDR_W-1:0]          i_sram_stop_addr;
    logic signed [SAMPLE_W-1:0] o_dac_data;
    logic                       o_en;
    logic [ADDR_W-1:0]          o_sram_addr;

    logic signed [SAMPLE_W-1:0] mem [MEM_DEPTH];
    logic [15:0]                lfsr_q;

    // reference model state
    int m_addr;
    int m_curr;
    int m_next;
    int m_out;
    int m_cnt;
    int cfg_speed;
    bit cfg_slow;
    bit cfg_lin;
    int stop_addr;

    int n_checks;
    int n_errors;
    int cycle_cnt = 0;

    aud_dsp dut_i (.*);

    assign i_sram_data = mem[o_sram_addr[5:0]];  // asynchronous read

    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    // 16 bit galois, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        int          k;
        v = 0;
        for (k = 0; k < n; k++) begin
            v = (v << 1) | lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    task automatic fill_memory();
        int i;
        for (i = 0; i < MEM_DEPTH; i++) begin
            if (i % 4 == 2)
                mem[i] = SAMPLE_W'(28672 + rand_bits(12));  // near full scale
            else if (i % 4 == 3)
                mem[i] = SAMPLE_W'(-32768 + int'(rand_bits(8)));
            else
                mem[i] = SAMPLE_W'(rand_bits(16));
        end
    endtask

    // one output frame of the player
    task automatic model_step();
        int sum;
        int d;
        sum = m_addr;
        if (!cfg_slow)
            sum = m_addr + cfg_speed + 1;
        else if (m_cnt == 0)
            sum = m_addr + 1;
        m_addr = (sum > stop_addr) ? 0 : sum;
        if (!cfg_slow || m_cnt == 0) begin
            m_curr = m_next;
            m_next = mem[m_addr];
        end
        if (cfg_slow && cfg_lin) begin
            d     = m_next - m_curr;
            m_out = m_curr + (d * m_cnt) / (cfg_speed + 1);  // int divide truncates to zero
        end else begin
            m_out = m_curr;
        end
        if (cfg_slow)
            m_cnt = (m_cnt == cfg_speed) ? 0 : m_cnt + 1;
    endtask

    task automatic check_sample(input logic signed [SAMPLE_W-1:0] got,
                                input logic signed [SAMPLE_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %0t ns: o_dac_data %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %0t ns: o_sram_addr %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_en(input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %0t ns: o_en %b, expected %b", $time, got, exp);
        end
    endtask

    // one daclrck period, optional resume pulse at the rise and pause pulse in the low half
    task automatic run_frame(input bit resume, input bit pause_after, input bit advance);
        @(posedge i_clk);
        #1;
        i_daclrck = 1'b1;
        i_pause   = resume;
        @(posedge i_clk);
        #1;
        i_pause = 1'b0;
        @(negedge i_clk);
        check_en(o_en, 1'b0);
        repeat (HALF_CYCLES - 2) @(posedge i_clk);
        @(posedge i_clk);
        #1;
        i_daclrck = 1'b0;
        @(negedge i_clk);
        if (advance)
            model_step();
        check_addr(o_sram_addr, ADDR_W'(m_addr));
        check_sample(o_dac_data, SAMPLE_W'(m_out));
        check_en(o_en, 1'b1);
        if (pause_after) begin
            repeat (3) @(posedge i_clk);
            #1;
            i_pause = 1'b1;  // lands in ST_SEND
            @(posedge i_clk);
            #1;
            i_pause = 1'b0;
            repeat (HALF_CYCLES - 5) @(posedge i_clk);
        end else begin
            repeat (HALF_CYCLES - 1) @(posedge i_clk);
        end
    endtask

    // config while paused, resume, play, pause again at the end
    task automatic play_segment(input logic [SPEED_W-1:0] spd, input bit slow, input bit lin,
                                input int nframes);
        int f;
        #1;
        i_speed     = spd;
        i_is_slow   = slow;
        i_slow_mode = lin;
        cfg_speed   = spd;
        cfg_slow    = slow;
        cfg_lin     = lin;
        m_next      = mem[m_addr];  // reloaded every paused cycle
        m_cnt       = 0;
        for (f = 0; f < nframes; f++) begin
            run_frame(f == 0, f == nframes - 1, 1'b1);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s finished with %0d errors", name, n_errors - errs_before);
    endtask

    initial begin
        int base;
        i_clk            = 1'b0;
        i_rst_n          = 1'b0;
        i_start          = 1'b0;
        i_pause          = 1'b0;
        i_speed          = '0;
        i_is_slow        = 1'b0;
        i_slow_mode      = 1'b0;
        i_daclrck        = 1'b0;
        i_sram_stop_addr = '0;
        n_checks         = 0;
        n_errors         = 0;
        m_addr           = 0;
        m_curr           = 0;
        m_next           = 0;
        m_out            = 0;
        m_cnt            = 0;
        lfsr_q           = 16'd62046;
        fill_memory();
        stop_addr        = 16 + rand_bits(5);
        i_sram_stop_addr = ADDR_W'(stop_addr);

        repeat (8) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        @(posedge i_clk);
        #1;
        i_start = 1'b1;
        @(posedge i_clk);
        #1;
        i_start = 1'b0;

        base = n_errors;
        repeat (4) run_frame(1'b0, 1'b0, 1'b0);  // started but still paused
        report_test("idle after start", base);

        base = n_errors;
        repeat (3) play_segment(SPEED_W'(rand_bits(SPEED_W)), 1'b0, 1'b0, 8);
        report_test("fast mode", base);

        base = n_errors;
        repeat (2) play_segment(SPEED_W'(rand_bits(SPEED_W)), 1'b1, 1'b0, 10);
        report_test("slow repeat", base);

        base = n_errors;
        repeat (2) play_segment(SPEED_W'(rand_bits(SPEED_W)), 1'b1, 1'b1, 12);
        report_test("slow linear", base);

        base = n_errors;
        play_segment(SPEED_W'(rand_bits(SPEED_W)), 1'b0, 1'b0, 8);
        repeat (3) run_frame(1'b0, 1'b0, 1'b0);  // frozen
        play_segment(SPEED_W'(rand_bits(SPEED_W)), 1'b1, 1'b1, 8);
        report_test("pause and resume", base);

        $display("summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- sim.f
verilog/aud_pkg.sv
verilog/aud_ctrl_if.sv
verilog/aud_play_fsm.sv
verilog/aud_step_counter.sv
verilog/aud_addr_gen.sv
verilog/aud_interp.sv
verilog/aud_dsp.sv
bench/aud_dsp_properties.sv
bench/aud_dsp_tb.sv

//--- Makefile
TOP := aud_dsp_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir
